// ==== filelist.f ====
source/pcs_rx_pkg.sv
source/block_sync_lane.sv
source/descrambler_lane.sv
source/idle_pattern_checker.sv
source/cor_status.sv
source/pcs_rx_front.sv
test/pcs_rx_front_assert.sv
test/pcs_rx_front_tb.sv

// ==== test/pcs_rx_front_tb.sv ====
// four-lane run with idle and data traffic; lane offsets and scrambler seeds are random under a fixed seed
`timescale 1ns/1ps

module pcs_rx_front_tb;

    localparam int LOCK_WAIT   = pcs_rx_pkg::NB_BLOCK * (pcs_rx_pkg::SH_LOCK_COUNT + 1);
    localparam int STIM_CYCLES = 2 * (2 * LOCK_WAIT + 300) + 100;
    localparam int TIMEOUT     = 2 * STIM_CYCLES + 2000;

    // traffic kinds for one strobe
    localparam int K_IDLE    = 0;
    localparam int K_DATA    = 1;
    localparam int K_PLAIN   = 2;
    localparam int K_CORRUPT = 3;

    logic         clock;
    logic         reset;
    logic         valid;
    logic [263:0] phy_data;
    logic         bypass;
    logic         idle_mode;
    logic         read_lock;
    logic         read_mismatch;
    logic [3:0]   block_lock;
    logic [3:0]   lock_latched;
    logic [31:0]  mismatch_count;

    logic [65:0] prev_blk  [4];
    int          offset    [4];
    logic [57:0] scr_state [4];
    logic [57:0] ref_state [4];
    // the receiver judges each block one strobe after it was sent
    bit          pending   [4];
    int          errors;
    int          exp_count;
    bit          counting;
    int          cycles;
    int          seed_value;

    pcs_rx_front i_dut
    (
        .i_clock              (clock),
        .i_reset              (reset),
        .i_valid              (valid),
        .i_phy_data           (phy_data),
        .i_descrambler_bypass (bypass),
        .i_idle_pattern_mode  (idle_mode),
        .i_read_block_lock    (read_lock),
        .i_read_mismatch      (read_mismatch),
        .o_block_lock         (block_lock),
        .o_lock_latched       (lock_latched),
        .o_mismatch_count     (mismatch_count)
    );

    always #2 clock = ~clock;

    always @(posedge clock)
    begin
        cycles++;
        if (cycles >= TIMEOUT)
        begin
            $display("timeout after %0d cycles, the DUT never finished, %0d errors", cycles, errors);
            $display("Testbench failed");
            $finish;
        end
    end

    // x^58 + x^39 + 1 scrambler with state bit 0 as the newest output bit
    function automatic logic [63:0] scramble(input int lane, input logic [63:0] plain);
        logic [63:0] out;
        logic [57:0] st;
        st = scr_state[lane];
        for (int i = 0; i < 64; i++)
        begin
            out[i] = plain[i] ^ st[38] ^ st[57];
            st = {st[56:0], out[i]};
        end
        scr_state[lane] = st;
        return out;
    endfunction

    // descramble like the receiver and decide whether the block counts as a mismatch
    function automatic bit ref_counts(input int lane, input logic [65:0] blk, input bit byp);
        logic [63:0] clear;
        logic [57:0] st;
        logic [65:0] seen;
        st = ref_state[lane];
        for (int i = 0; i < 64; i++)
        begin
            clear[i] = blk[i] ^ st[38] ^ st[57];
            st = {st[56:0], blk[i]};
        end
        ref_state[lane] = st;
        seen = {blk[65:64], byp ? blk[63:0] : clear};
        return !((seen[65:64] == 2'b10) && (seen[63:56] == 8'h1e) && (seen[55:0] == '0));
    endfunction

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // one block per lane with each lane stream delayed by its own bit offset
    task automatic send_strobe(input int kind, input int bad_lane);
        logic [65:0]  blk;
        logic [131:0] pair;
        logic [263:0] words;
        logic [63:0]  pl;
        logic [1:0]   sh;
        for (int lane = 0; lane < 4; lane++)
        begin
            if (counting && pending[lane])
                exp_count++;
            if (kind == K_DATA)
            begin
                pl = {$urandom, $urandom};
                sh = 2'b01;
            end
            else
            begin
                pl = {8'h1e, 56'h0};
                sh = 2'b10;
            end
            blk = {sh, (kind == K_PLAIN) ? pl : scramble(lane, pl)};
            if (kind == K_CORRUPT && lane == bad_lane)
                blk[65:64] = 2'b11;
            pending[lane] = ref_counts(lane, blk, bypass);
            pair = {blk, prev_blk[lane]};
            pair = pair >> (66 - offset[lane]);
            words[lane*66 +: 66] = pair[65:0];
            prev_blk[lane] = blk;
        end
        @(posedge clock);
        valid    <= 1'b1;
        phy_data <= words;
        @(posedge clock);
        valid    <= 1'b0;
    endtask

    // the next strobe moves the last block in and the count shows it two cycles later
    task automatic drain(input int kind);
        send_strobe(kind, 0);
        repeat (2) @(posedge clock);
        @(negedge clock);
    endtask

    task automatic read_pulse(input bit mismatch);
        @(posedge clock);
        if (mismatch)
            read_mismatch <= 1'b1;
        else
            read_lock <= 1'b1;
        @(posedge clock);
        read_mismatch <= 1'b0;
        read_lock     <= 1'b0;
        if (mismatch)
            exp_count = 0;
        @(negedge clock);
    endtask

    task automatic wait_lock();
        int n;
        n = 0;
        while (block_lock != 4'hf && n < LOCK_WAIT)
        begin
            send_strobe(K_IDLE, 0);
            @(negedge clock);
            n++;
        end
        if (block_lock != 4'hf)
            $display("lanes failed to lock within %0d strobes", LOCK_WAIT);
        check_value("o_block_lock", block_lock, 4'hf);
    endtask

    initial
    begin
        seed_value = $urandom(32'haea3_ba0f);
        clock = 1'b0;
        reset = 1'b1;
        valid = 1'b0;
        phy_data = '0;
        bypass = 1'b0;
        idle_mode = 1'b1;
        read_lock = 1'b0;
        read_mismatch = 1'b0;
        errors = 0;
        exp_count = 0;
        counting = 1'b0;
        cycles = 0;
        for (int lane = 0; lane < 4; lane++)
        begin
            offset[lane]    = $urandom % 66;
            scr_state[lane] = {$urandom, $urandom};
            ref_state[lane] = '0;
            prev_blk[lane]  = '0;
            pending[lane]   = 1'b0;
        end
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        // lock on all lanes and hold it
        wait_lock();
        repeat (20) send_strobe(K_IDLE, 0);
        @(negedge clock);
        check_value("o_block_lock", block_lock, 4'hf);
        read_pulse(0);
        check_value("o_lock_latched", lock_latched, 4'hf);

        // idle only keeps the count at zero
        counting = 1'b1;
        read_pulse(1);
        check_value("o_mismatch_count", mismatch_count, 0);
        repeat (40) send_strobe(K_IDLE, 0);
        drain(K_IDLE);
        check_value("o_mismatch_count", mismatch_count, exp_count);

        // injected data blocks
        repeat (5) send_strobe(K_DATA, 0);
        drain(K_IDLE);
        check_value("o_mismatch_count", mismatch_count, exp_count);

        // clear on read and resume counting
        read_pulse(1);
        check_value("o_mismatch_count", mismatch_count, 0);
        repeat (3) send_strobe(K_DATA, 0);
        drain(K_IDLE);
        check_value("o_mismatch_count", mismatch_count, exp_count);

        // twice the limit of bad headers on lane 0 so that one window holds enough
        counting = 1'b0;
        repeat (2 * pcs_rx_pkg::SH_INVALID_LIMIT) send_strobe(K_CORRUPT, 0);
        @(negedge clock);
        check_value("o_block_lock", block_lock[0], 0);
        check_value("o_lock_latched", lock_latched[0], 0);
        wait_lock();
        check_value("o_lock_latched", lock_latched, 4'he);
        read_pulse(0);
        check_value("o_lock_latched", lock_latched, 4'hf);

        // in bypass every locked scrambled idle block counts
        @(posedge clock);
        bypass <= 1'b1;
        repeat (4) send_strobe(K_IDLE, 0);
        counting = 1'b1;
        read_pulse(1);
        repeat (10) send_strobe(K_IDLE, 0);
        drain(K_IDLE);
        check_value("o_mismatch_count", mismatch_count, exp_count);

        // bypass with plain idle counts nothing
        repeat (4) send_strobe(K_PLAIN, 0);
        read_pulse(1);
        repeat (10) send_strobe(K_PLAIN, 0);
        drain(K_PLAIN);
        check_value("o_mismatch_count", mismatch_count, 0);

        $display("run complete, %0d errors", errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== test/pcs_rx_front_assert.sv ====
// bound to pcs_rx_front; checks are off while reset is high
`timescale 1ns/1ps

module pcs_rx_front_assert
(
    input logic                               i_clock,
    input logic                               i_reset,
    input logic                               i_valid,
    input logic                               i_read_block_lock,
    input logic [pcs_rx_pkg::N_LANES-1:0]     i_block_lock,
    input logic [pcs_rx_pkg::N_LANES-1:0]     i_lock_latched,
    input logic [pcs_rx_pkg::NB_MISMATCH-1:0] i_mismatch_count,
    input logic                               i_clear,
    input logic [pcs_rx_pkg::N_LANES-1:0]     i_sync_valid
);

    // a latched bit rises only right after the first cycle of a block-lock read
    latched_rise_on_read: assert property (@(posedge i_clock) disable iff (i_reset)
        ((i_lock_latched & ~$past(i_lock_latched)) != '0) |->
            ($past(i_read_block_lock) && !$past(i_read_block_lock, 2)))
        else $error("latched lock bit rose without a block-lock read");

    // only a clear pulse may lower the count
    count_monotonic: assert property (@(posedge i_clock) disable iff (i_reset)
        !i_clear |=> (i_mismatch_count >= $past(i_mismatch_count)))
        else $error("mismatch count decreased without a clear");

    lane_valid_delay: assert property (@(posedge i_clock) disable iff (i_reset)
        1'b1 |=> (i_sync_valid == {pcs_rx_pkg::N_LANES{$past(i_valid)}}))
        else $error("lane valid does not follow the input valid by one cycle");

endmodule

bind pcs_rx_front pcs_rx_front_assert u_assert
(
    .i_clock           (i_clock),
    .i_reset           (i_reset),
    .i_valid           (i_valid),
    .i_read_block_lock (i_read_block_lock),
    .i_block_lock      (o_block_lock),
    .i_lock_latched    (o_lock_latched),
    .i_mismatch_count  (o_mismatch_count),
    .i_clear           (clear_mismatch),
    .i_sync_valid      (sync_valid)
);

// ==== source/pcs_rx_front.sv ====
// no back-pressure; i_valid must be a one-cycle strobe and the mode inputs static while running
`timescale 1ns/1ps

module pcs_rx_front
(
    input  logic                                               i_clock,
    input  logic                                               i_reset,
    input  logic                                               i_valid,
    input  logic [pcs_rx_pkg::N_LANES*pcs_rx_pkg::NB_BLOCK-1:0] i_phy_data,
    input  logic                                               i_descrambler_bypass,
    input  logic                                               i_idle_pattern_mode,
    input  logic                                               i_read_block_lock,
    input  logic                                               i_read_mismatch,
    output logic [pcs_rx_pkg::N_LANES-1:0]                     o_block_lock,
    output logic [pcs_rx_pkg::N_LANES-1:0]                     o_lock_latched,
    output logic [pcs_rx_pkg::NB_MISMATCH-1:0]                 o_mismatch_count
);

    // block sync to descrambler
    pcs_rx_pkg::pcs_block_t [pcs_rx_pkg::N_LANES-1:0] sync_blocks;
    logic [pcs_rx_pkg::N_LANES-1:0]                   sync_valid;

    // descrambler to checker
    pcs_rx_pkg::pcs_block_t [pcs_rx_pkg::N_LANES-1:0] descr_blocks;
    logic [pcs_rx_pkg::N_LANES-1:0]                   descr_valid;

    logic clear_mismatch;

    genvar lane;
    generate
        for (lane = 0; lane < pcs_rx_pkg::N_LANES; lane++)
        begin : g_lane
            block_sync_lane u_block_sync
            (
                .i_clock (i_clock),
                .i_reset (i_reset),
                .i_valid (i_valid),
                .i_raw   (i_phy_data[lane*pcs_rx_pkg::NB_BLOCK +: pcs_rx_pkg::NB_BLOCK]),
                .o_block (sync_blocks[lane]),
                .o_valid (sync_valid[lane]),
                .o_lock  (o_block_lock[lane])
            );

            descrambler_lane u_descrambler
            (
                .i_clock  (i_clock),
                .i_reset  (i_reset),
                .i_valid  (sync_valid[lane]),
                .i_block  (sync_blocks[lane]),
                .i_bypass (i_descrambler_bypass),
                .o_block  (descr_blocks[lane]),
                .o_valid  (descr_valid[lane])
            );
        end
    endgenerate

    idle_pattern_checker u_checker
    (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_valid       (descr_valid),
        .i_blocks      (descr_blocks),
        .i_lock        (o_block_lock),
        .i_enable_idle (i_idle_pattern_mode),
        .i_clear       (clear_mismatch),
        .o_count       (o_mismatch_count)
    );

    cor_status u_cor_status
    (
        .i_clock           (i_clock),
        .i_reset           (i_reset),
        .i_lock            (o_block_lock),
        .i_read_block_lock (i_read_block_lock),
        .i_read_mismatch   (i_read_mismatch),
        .o_lock_latched    (o_lock_latched),
        .o_clear_mismatch  (clear_mismatch)
    );

endmodule

// ==== source/cor_status.sv ====
// only the rising edge of a read pulse acts; a held read pulse does nothing after its first cycle
`timescale 1ns/1ps

module cor_status
(
    input  logic                           i_clock,
    input  logic                           i_reset,
    input  logic [pcs_rx_pkg::N_LANES-1:0] i_lock,
    input  logic                           i_read_block_lock,
    input  logic                           i_read_mismatch,
    output logic [pcs_rx_pkg::N_LANES-1:0] o_lock_latched,
    output logic                           o_clear_mismatch
);

    logic                           read_block_lock_d;
    logic                           read_mismatch_d;
    logic                           block_lock_edge;
    logic [pcs_rx_pkg::N_LANES-1:0] lock_latched_q;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            read_block_lock_d <= 1'b0;
            read_mismatch_d   <= 1'b0;
        end
        else
        begin
            read_block_lock_d <= i_read_block_lock;
            read_mismatch_d   <= i_read_mismatch;
        end
    end

    assign block_lock_edge  = i_read_block_lock & ~read_block_lock_d;
    assign o_clear_mismatch = i_read_mismatch & ~read_mismatch_d;

    // latched low, reload from live bits on a read
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            lock_latched_q <= '0;
        else if (block_lock_edge)
            lock_latched_q <= i_lock;
        else
            lock_latched_q <= lock_latched_q & i_lock;
    end

    // a drop shows in the same cycle as the live bit
    assign o_lock_latched = lock_latched_q & i_lock;

endmodule

// ==== source/idle_pattern_checker.sv ====
// counts only in idle mode on valid, locked lanes; saturates at all ones, clear wins over any hits
`timescale 1ns/1ps

module idle_pattern_checker
(
    input  logic                                          i_clock,
    input  logic                                          i_reset,
    input  logic [pcs_rx_pkg::N_LANES-1:0]                i_valid,
    input  pcs_rx_pkg::pcs_block_t [pcs_rx_pkg::N_LANES-1:0] i_blocks,
    input  logic [pcs_rx_pkg::N_LANES-1:0]                i_lock,
    input  logic                                          i_enable_idle,
    input  logic                                          i_clear,
    output logic [pcs_rx_pkg::NB_MISMATCH-1:0]            o_count
);

    logic [pcs_rx_pkg::N_LANES-1:0]     lane_idle;
    logic [pcs_rx_pkg::N_LANES-1:0]     lane_hit;
    logic [pcs_rx_pkg::NB_LANE_SUM-1:0] hit_sum;
    logic [pcs_rx_pkg::NB_MISMATCH:0]   count_sum;

    always_comb
    begin
        hit_sum = '0;
        for (int lane = 0; lane < pcs_rx_pkg::N_LANES; lane++)
        begin
            // idle is control header, type 1e and every control character zero
            lane_idle[lane] = (i_blocks[lane].ctrl.sh == pcs_rx_pkg::SH_CTRL) &&
                              (i_blocks[lane].ctrl.block_type == pcs_rx_pkg::IDLE_BLOCK_TYPE) &&
                              (i_blocks[lane].ctrl.chars == '0);
            lane_hit[lane]  = i_enable_idle && i_valid[lane] && i_lock[lane] && !lane_idle[lane];
            hit_sum = hit_sum + pcs_rx_pkg::NB_LANE_SUM'(lane_hit[lane]);
        end
    end

    // one spare bit on top catches the overflow
    assign count_sum = {1'b0, o_count} +
                       {{(pcs_rx_pkg::NB_MISMATCH + 1 - pcs_rx_pkg::NB_LANE_SUM){1'b0}}, hit_sum};

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_count <= '0;
        else if (i_clear)
            o_count <= '0;
        else if (count_sum[pcs_rx_pkg::NB_MISMATCH])
            o_count <= '1;
        else
            o_count <= count_sum[pcs_rx_pkg::NB_MISMATCH-1:0];
    end

endmodule

// ==== source/descrambler_lane.sv ====
// payload only, header is untouched; state keeps advancing on scrambled bits even in bypass
`timescale 1ns/1ps

module descrambler_lane
(
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_valid,
    input  pcs_rx_pkg::pcs_block_t i_block,
    input  logic                   i_bypass,
    output pcs_rx_pkg::pcs_block_t o_block,
    output logic                   o_valid
);

    logic [pcs_rx_pkg::SCR_TAP_HI-1:0] scr_state;
    logic [pcs_rx_pkg::SCR_TAP_HI-1:0] scr_walk;
    logic [pcs_rx_pkg::SCR_TAP_HI-1:0] scr_state_next;
    logic [pcs_rx_pkg::NB_PAYLOAD-1:0] clear_payload;

    // bit 0 of the state is the most recently received bit
    always_comb
    begin
        scr_walk = scr_state;
        for (int i = 0; i < pcs_rx_pkg::NB_PAYLOAD; i++)
        begin
            clear_payload[i] = i_block.data.payload[i] ^
                               scr_walk[pcs_rx_pkg::SCR_TAP_LO-1] ^
                               scr_walk[pcs_rx_pkg::SCR_TAP_HI-1];
            scr_walk = {scr_walk[pcs_rx_pkg::SCR_TAP_HI-2:0], i_block.data.payload[i]};
        end
        scr_state_next = scr_walk;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            scr_state <= '0;
            o_valid   <= 1'b0;
        end
        else
        begin
            o_valid <= i_valid;
            if (i_valid)
                scr_state <= scr_state_next;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            o_block.data.sh      <= i_block.data.sh;
            o_block.data.payload <= i_bypass ? i_block.data.payload : clear_payload;
        end
    end

endmodule

// ==== source/block_sync_lane.sv ====
// lock needs SH_LOCK_COUNT good headers in a row; slip moves one bit per bad header while unlocked
`timescale 1ns/1ps

module block_sync_lane
(
    input  logic                            i_clock,
    input  logic                            i_reset,
    input  logic                            i_valid,
    input  logic [pcs_rx_pkg::NB_BLOCK-1:0] i_raw,
    output pcs_rx_pkg::pcs_block_t          o_block,
    output logic                            o_valid,
    output logic                            o_lock
);

    logic [pcs_rx_pkg::NB_BLOCK-1:0]       prev_raw;
    logic [2*pcs_rx_pkg::NB_BLOCK-1:0]     raw_pair;
    pcs_rx_pkg::pcs_block_t                cand_block;
    logic                                  sh_ok;
    logic [pcs_rx_pkg::NB_SLIP-1:0]        slip;
    logic [pcs_rx_pkg::NB_SLIP-1:0]        slip_next;
    logic [pcs_rx_pkg::NB_LOCK_CNT-1:0]    good_cnt;
    logic [pcs_rx_pkg::NB_WINDOW_CNT-1:0]  window_cnt;
    logic [pcs_rx_pkg::NB_INVALID_CNT-1:0] invalid_cnt;

    // older word in the low half, so offset 0 picks the previous word as is
    assign raw_pair   = {i_raw, prev_raw};
    assign cand_block = raw_pair[slip +: pcs_rx_pkg::NB_BLOCK];

    assign sh_ok = (cand_block.data.sh == pcs_rx_pkg::SH_DATA) ||
                   (cand_block.data.sh == pcs_rx_pkg::SH_CTRL);

    // offset wraps after 65
    assign slip_next = (slip == pcs_rx_pkg::NB_SLIP'(pcs_rx_pkg::NB_BLOCK - 1)) ?
                       '0 : slip + 1'b1;

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
        begin
            prev_raw <= i_raw;
            o_block  <= cand_block;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_valid <= 1'b0;
        else
            o_valid <= i_valid;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_lock      <= 1'b0;
            slip        <= '0;
            good_cnt    <= '0;
            window_cnt  <= '0;
            invalid_cnt <= '0;
        end
        else if (i_valid)
        begin
            if (!o_lock)
            begin
                window_cnt  <= '0;
                invalid_cnt <= '0;
                if (!sh_ok)
                begin
                    good_cnt <= '0;
                    slip     <= slip_next;
                end
                else if (good_cnt == pcs_rx_pkg::NB_LOCK_CNT'(pcs_rx_pkg::SH_LOCK_COUNT - 1))
                begin
                    o_lock   <= 1'b1;
                    good_cnt <= '0;
                end
                else
                begin
                    good_cnt <= good_cnt + 1'b1;
                end
            end
            else
            begin
                // too many bad headers in this window, drop lock and hunt again
                if (!sh_ok && (invalid_cnt ==
                    pcs_rx_pkg::NB_INVALID_CNT'(pcs_rx_pkg::SH_INVALID_LIMIT - 1)))
                begin
                    o_lock      <= 1'b0;
                    slip        <= slip_next;
                    window_cnt  <= '0;
                    invalid_cnt <= '0;
                end
                else if (window_cnt == pcs_rx_pkg::NB_WINDOW_CNT'(pcs_rx_pkg::SH_WINDOW - 1))
                begin
                    window_cnt  <= '0;
                    invalid_cnt <= '0;
                end
                else
                begin
                    window_cnt <= window_cnt + 1'b1;
                    if (!sh_ok)
                        invalid_cnt <= invalid_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/pcs_rx_pkg.sv ====
// fixed four-lane build; block bit 0 is the earliest received bit and the sync header sits in bits 65:64
package pcs_rx_pkg;

    // lane and block geometry
    localparam int N_LANES       = 4;
    localparam int NB_BLOCK      = 66;
    localparam int NB_SH         = 2;
    localparam int NB_PAYLOAD    = NB_BLOCK - NB_SH;
    localparam int NB_BLOCK_TYPE = 8;
    localparam int NB_CTRL_CHARS = NB_PAYLOAD - NB_BLOCK_TYPE;
    localparam int NB_SLIP       = 7;

    // sync header values and lock limits
    localparam logic [NB_SH-1:0] SH_DATA = 2'b01;
    localparam logic [NB_SH-1:0] SH_CTRL = 2'b10;
    localparam int SH_LOCK_COUNT    = 64;
    localparam int SH_WINDOW        = 1024;
    localparam int SH_INVALID_LIMIT = 65;
    localparam int NB_LOCK_CNT      = $clog2(SH_LOCK_COUNT + 1);
    localparam int NB_WINDOW_CNT    = $clog2(SH_WINDOW);
    localparam int NB_INVALID_CNT   = $clog2(SH_INVALID_LIMIT + 1);

    // x^58 + x^39 + 1, state width equals the high tap
    localparam int SCR_TAP_HI = 58;
    localparam int SCR_TAP_LO = 39;

    // idle control block and mismatch counter
    localparam logic [NB_BLOCK_TYPE-1:0] IDLE_BLOCK_TYPE = 8'h1e;
    localparam int NB_MISMATCH = 32;
    localparam int NB_LANE_SUM = $clog2(N_LANES + 1);

    typedef struct packed {
        logic [NB_SH-1:0]      sh;
        logic [NB_PAYLOAD-1:0] payload;
    } pcs_data_view_t;

    // block type is the byte right under the header
    typedef struct packed {
        logic [NB_SH-1:0]         sh;
        logic [NB_BLOCK_TYPE-1:0] block_type;
        logic [NB_CTRL_CHARS-1:0] chars;
    } pcs_ctrl_view_t;

    typedef union packed {
        pcs_data_view_t data;
        pcs_ctrl_view_t ctrl;
    } pcs_block_t;

endpackage
